//--- files.f
rtl/ctrl_link_pkg.sv
rtl/link_tx.sv
rtl/link_rx.sv
rtl/ctrl_master.sv
rtl/ctrl_slave.sv
rtl/link_top.sv
verif/link_chk.sv
verif/link_tb.sv

//--- run.sh
#!/bin/sh
# build and run the link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module link_tb -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vlink_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi
exit 1

//--- verif/link_tb.sv
module link_tb
  import ctrl_link_pkg::*;
();

  localparam int BIT_CYCLES    = 4;
  localparam int REPLY_TIMEOUT = 64;
  localparam int N_CMDS        = 84;
  // one command frame, one reply frame, the reply wait and handshake slack
  localparam int CMD_BUDGET    =
    (CMD_FRAME_BITS + REPLY_FRAME_BITS) * BIT_CYCLES + REPLY_TIMEOUT + 16;
  localparam int CYCLE_LIMIT   = N_CMDS * CMD_BUDGET + 64;

  typedef struct packed {
    rsp_status_t status;
    logic [7:0]  data;
  } expect_t;

  logic        clk_sys = 1'b0;
  logic        arst_n;
  logic        cmd_req;
  cmd_frame_t  cmd;
  logic        cmd_ack;
  rsp_status_t rsp_status;
  logic [7:0]  rsp_data;

  logic [7:0]  shadow0 [2**REG_AW];
  logic [7:0]  shadow1 [2**REG_AW];
  expect_t     exp_q [$];
  logic [31:0] rng_state = 32'd39;
  logic        ack_q = 1'b0;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark;
  int          chk_mark;

  link_top #(
    .BIT_CYCLES    (BIT_CYCLES),
    .REPLY_TIMEOUT (REPLY_TIMEOUT)
  ) dut0 (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .cmd_req    (cmd_req),
    .cmd        (cmd),
    .cmd_ack    (cmd_ack),
    .rsp_status (rsp_status),
    .rsp_data   (rsp_data)
  );

  bind link_top link_chk chk0 (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .tx_ctrl (tx_ctrl)
  );

  always #5 clk_sys = ~clk_sys;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // expected result from the shadow register files, applying writes
  function automatic expect_t ref_model(input cmd_frame_t c);
    expect_t           e;
    logic [REG_AW-1:0] a;
    a      = c.addr[REG_AW-1:0];
    e.data = 8'h00;
    if (c.dev_id == BCAST_ID) begin
      if (c.wr) begin
        shadow0[a] = c.data;
        shadow1[a] = c.data;
      end
      e.status = ST_BCAST;
      e.data   = c.data;
    end else if (c.dev_id == 8'h01) begin
      if (c.wr) begin
        shadow0[a] = c.data;
      end
      e.status = ST_OK;
      e.data   = shadow0[a];
    end else if (c.dev_id == 8'h02) begin
      if (c.wr) begin
        shadow1[a] = c.data;
      end
      e.status = ST_OK;
      e.data   = shadow1[a];
    end else begin
      e.status = ST_TIMEOUT;
    end
    return e;
  endfunction

  // one full four-phase handshake
  task automatic issue_cmd(input logic wr, input logic [7:0] dev_id,
                           input logic [7:0] addr, input logic [7:0] data);
    cmd_frame_t c;
    c.wr     = wr;
    c.dev_id = dev_id;
    c.addr   = addr;
    c.data   = data;
    @(negedge clk_sys);
    exp_q.push_back(ref_model(c));
    cmd     = c;
    cmd_req = 1'b1;
    do @(negedge clk_sys); while (!cmd_ack);
    // req stays up a little while the master holds ack
    repeat (2) @(negedge clk_sys);
    cmd_req = 1'b0;
    do @(negedge clk_sys); while (cmd_ack);
  endtask

  task automatic open_test();
    err_mark = errors;
    chk_mark = checks;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - chk_mark, errors - err_mark);
  endtask

  // compare on the first cycle the ack is seen high
  always @(posedge clk_sys) begin
    expect_t e;
    if (cmd_ack && !ack_q) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("cmd_ack at %0t with no command outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        checks++;
        assert (rsp_status == e.status) else begin
          $display("ERROR t=%0t rsp_status exp=%s got=%s", $time,
                   e.status.name(), rsp_status.name());
          errors++;
        end
        if (e.status != ST_TIMEOUT) begin
          checks++;
          assert (rsp_data == e.data) else begin
            $display("ERROR t=%0t rsp_data exp=%02h got=%02h", $time, e.data, rsp_data);
            errors++;
          end
        end
      end
    end
    ack_q <= cmd_ack;
  end

  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles, a command never completed", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic [7:0]  ids [4];
    logic [31:0] r;
    ids     = '{8'h01, 8'h02, 8'h07, BCAST_ID};
    arst_n  = 1'b0;
    cmd_req = 1'b0;
    cmd     = '0;
    for (int i = 0; i < 2**REG_AW; i++) begin
      shadow0[i] = 8'h00;
      shadow1[i] = 8'h00;
    end
    repeat (3) @(negedge clk_sys);
    arst_n = 1'b1;

    open_test();
    for (int id = 1; id <= 2; id++) begin
      for (int a = 0; a < 2**REG_AW; a++) begin
        issue_cmd(1'b0, 8'(id), 8'(a), 8'h00);
      end
    end
    report_test(1, "reads after reset");

    open_test();
    issue_cmd(1'b1, 8'h01, 8'h03, 8'hA5);
    issue_cmd(1'b0, 8'h01, 8'h03, 8'h00);
    issue_cmd(1'b1, 8'h02, 8'h09, 8'h3C);
    issue_cmd(1'b0, 8'h02, 8'h09, 8'h00);
    report_test(2, "write then read");

    open_test();
    issue_cmd(1'b1, 8'h01, 8'h06, 8'h77);
    issue_cmd(1'b0, 8'h02, 8'h06, 8'h00);
    issue_cmd(1'b0, 8'h01, 8'h06, 8'h00);
    report_test(3, "slave independence");

    open_test();
    issue_cmd(1'b0, 8'h07, 8'h01, 8'h00);
    issue_cmd(1'b1, 8'h07, 8'h02, 8'h5F);
    report_test(4, "absent device");

    open_test();
    issue_cmd(1'b1, BCAST_ID, 8'h0C, 8'h96);
    issue_cmd(1'b0, 8'h01, 8'h0C, 8'h00);
    issue_cmd(1'b0, 8'h02, 8'h0C, 8'h00);
    report_test(5, "broadcast write");

    open_test();
    for (int n = 0; n < 40; n++) begin
      r = next_random();
      issue_cmd(r[31], ids[r[1:0]], r[15:8], r[23:16]);
    end
    report_test(6, "random commands");

    repeat (4) @(negedge clk_sys);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results never arrived", exp_q.size());
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut0.chk0.fails);
    if (errors == 0 && dut0.chk0.fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verif/link_chk.sv
module link_chk
  import ctrl_link_pkg::*;
(
  input logic       clk_sys,
  input logic       arst_n,
  input logic       cmd_req,
  input cmd_frame_t cmd,
  input logic       cmd_ack,
  input logic       tx_ctrl
);

  // failure count, read by the testbench at the end of the run
  int fails = 0;

  // ack only answers a request seen the cycle before
  ack_needs_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
  else begin
    $error("cmd_ack rose with no cmd_req");
    fails++;
  end

  ack_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
    cmd_ack && cmd_req |=> cmd_ack)
  else begin
    $error("cmd_ack dropped while cmd_req still high");
    fails++;
  end

  cmd_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
    $past(cmd_req) && !$past(cmd_ack) && cmd_req |-> $stable(cmd))
  else begin
    $error("cmd changed during an open request");
    fails++;
  end

  // no req and no ack means the master sits in idle
  idle_line_high: assert property (@(posedge clk_sys) disable iff (!arst_n)
    !cmd_req && !cmd_ack |-> tx_ctrl)
  else begin
    $error("tx_ctrl low while the master is idle");
    fails++;
  end

endmodule

//--- rtl/link_top.sv
module link_top
  import ctrl_link_pkg::*;
#(
  parameter int BIT_CYCLES    = 4,
  parameter int REPLY_TIMEOUT = 64
) (
  input  logic        clk_sys,
  input  logic        arst_n,
  input  logic        cmd_req,
  input  cmd_frame_t  cmd,
  output logic        cmd_ack,
  output rsp_status_t rsp_status,
  output logic [7:0]  rsp_data
);

  logic tx_ctrl;
  logic tx_a0;
  logic tx_a1;
  logic rx_a;

  ctrl_master #(
    .BIT_CYCLES    (BIT_CYCLES),
    .REPLY_TIMEOUT (REPLY_TIMEOUT)
  ) u_master (
    .clk_sys    (clk_sys),
    .arst_n     (arst_n),
    .cmd_req    (cmd_req),
    .cmd        (cmd),
    .cmd_ack    (cmd_ack),
    .rsp_status (rsp_status),
    .rsp_data   (rsp_data),
    .tx_ctrl    (tx_ctrl),
    .rx_a       (rx_a)
  );

  // both slaves listen on the same control line
  ctrl_slave #(
    .BIT_CYCLES (BIT_CYCLES),
    .DEV_ID     (8'h01)
  ) slave0 (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .rx_ctrl (tx_ctrl),
    .tx_a    (tx_a0)
  );

  ctrl_slave #(
    .BIT_CYCLES (BIT_CYCLES),
    .DEV_ID     (8'h02)
  ) slave1 (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .rx_ctrl (tx_ctrl),
    .tx_a    (tx_a1)
  );

  // idle-high lines, wired-and onto one return
  assign rx_a = tx_a0 & tx_a1;

endmodule

//--- rtl/ctrl_slave.sv
module ctrl_slave
  import ctrl_link_pkg::*;
#(
  parameter int         BIT_CYCLES = 4,
  parameter logic [7:0] DEV_ID     = 8'h01
) (
  input  logic clk_sys,
  input  logic arst_n,
  input  logic rx_ctrl,
  output logic tx_a
);

  logic              rx_valid;
  cmd_frame_t        rx_cmd;
  logic              tx_send;
  logic              tx_busy;
  reply_frame_t      reply_q;
  logic [7:0]        regs [2**REG_AW];
  logic [REG_AW-1:0] ra;
  logic              own;
  logic              hit;
  logic [7:0]        reg_after;

  assign ra  = rx_cmd.addr[REG_AW-1:0];
  assign own = (rx_cmd.dev_id == DEV_ID);
  assign hit = own || (rx_cmd.dev_id == BCAST_ID);

  // value the register holds once this command is applied
  assign reg_after = rx_cmd.wr ? rx_cmd.data : regs[ra];

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (rx_valid && hit && rx_cmd.wr) begin
      regs[ra] <= rx_cmd.data;
    end
  end

  // reply goes out the cycle after the frame lands
  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      tx_send <= 1'b0;
    end else begin
      tx_send <= rx_valid && own && !tx_busy;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (rx_valid && own) begin
      reply_q.dev_id <= rx_cmd.dev_id;
      reply_q.addr   <= rx_cmd.addr;
      reply_q.data   <= reg_after;
    end
  end

  link_rx #(
    .BIT_CYCLES (BIT_CYCLES),
    .payload_t  (cmd_frame_t)
  ) u_rx (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .line    (rx_ctrl),
    .valid   (rx_valid),
    .payload (rx_cmd)
  );

  link_tx #(
    .BIT_CYCLES (BIT_CYCLES),
    .payload_t  (reply_frame_t)
  ) u_tx (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .send    (tx_send),
    .payload (reply_q),
    .busy    (tx_busy),
    .line    (tx_a)
  );

endmodule

//--- rtl/ctrl_master.sv
module ctrl_master
  import ctrl_link_pkg::*;
#(
  parameter int BIT_CYCLES    = 4,
  parameter int REPLY_TIMEOUT = 64
) (
  input  logic        clk_sys,
  input  logic        arst_n,
  input  logic        cmd_req,
  input  cmd_frame_t  cmd,
  output logic        cmd_ack,
  output rsp_status_t rsp_status,
  output logic [7:0]  rsp_data,
  output logic        tx_ctrl,
  input  logic        rx_a
);

  localparam int TW = $clog2(REPLY_TIMEOUT + 1);

  typedef enum logic [1:0] {
    M_IDLE,
    M_SEND,
    M_WAIT,
    M_ACK
  } m_state_t;

  m_state_t      state;
  cmd_frame_t    cmd_q;
  logic          tx_send;
  logic          tx_busy;
  logic          rx_valid;
  reply_frame_t  rx_frame;
  logic [TW-1:0] quiet;
  logic          heard;
  logic          frame_done;
  logic          bcast;
  logic          reply_hit;
  logic          timed_out;

  assign tx_send    = (state == M_IDLE) && cmd_req;
  assign frame_done = (state == M_SEND) && !tx_busy;
  assign bcast      = (cmd_q.dev_id == BCAST_ID);
  // a stale or foreign reply does not end the wait
  assign reply_hit  = (state == M_WAIT) && rx_valid &&
                      (rx_frame.dev_id == cmd_q.dev_id) && (rx_frame.addr == cmd_q.addr);
  // quiet counts wait cycles until a reply start bit shows up
  assign timed_out  = (state == M_WAIT) && !heard && rx_a &&
                      (quiet == TW'(REPLY_TIMEOUT - 1));

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state   <= M_IDLE;
      cmd_ack <= 1'b0;
      quiet   <= '0;
      heard   <= 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          if (cmd_req) begin
            state <= M_SEND;
          end
        end
        M_SEND: begin
          if (!tx_busy) begin
            quiet <= '0;
            heard <= 1'b0;
            if (bcast) begin
              state   <= M_ACK;
              cmd_ack <= 1'b1;
            end else begin
              state <= M_WAIT;
            end
          end
        end
        M_WAIT: begin
          if (reply_hit || timed_out) begin
            state   <= M_ACK;
            cmd_ack <= 1'b1;
          end else if (!rx_a) begin
            heard <= 1'b1;
          end else if (!heard) begin
            quiet <= quiet + 1'b1;
          end
        end
        M_ACK: begin
          // hold the result until the host drops req
          if (!cmd_req) begin
            state   <= M_IDLE;
            cmd_ack <= 1'b0;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (tx_send) begin
      cmd_q <= cmd;
    end
    if (frame_done && bcast) begin
      rsp_status <= ST_BCAST;
      rsp_data   <= cmd_q.data;
    end else if (reply_hit) begin
      rsp_status <= ST_OK;
      rsp_data   <= rx_frame.data;
    end else if (timed_out) begin
      rsp_status <= ST_TIMEOUT;
      rsp_data   <= 8'h00;
    end
  end

  link_tx #(
    .BIT_CYCLES (BIT_CYCLES),
    .payload_t  (cmd_frame_t)
  ) u_tx (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .send    (tx_send),
    .payload (cmd),
    .busy    (tx_busy),
    .line    (tx_ctrl)
  );

  link_rx #(
    .BIT_CYCLES (BIT_CYCLES),
    .payload_t  (reply_frame_t)
  ) u_rx (
    .clk_sys (clk_sys),
    .arst_n  (arst_n),
    .line    (rx_a),
    .valid   (rx_valid),
    .payload (rx_frame)
  );

endmodule

//--- rtl/link_rx.sv
module link_rx #(
  parameter int  BIT_CYCLES = 4,
  parameter type payload_t  = logic [7:0]
) (
  input  logic     clk_sys,
  input  logic     arst_n,
  input  logic     line,
  output logic     valid,
  output payload_t payload
);

  localparam int PW    = $bits(payload_t);
  localparam int NBITS = PW + 2;
  localparam int CW    = $clog2(BIT_CYCLES + 1);
  localparam int BW    = $clog2(NBITS + 1);
  localparam int HALF  = (BIT_CYCLES - 1) / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_BITS,
    RX_DROP
  } rx_state_t;

  rx_state_t     state;
  logic [1:0]    sync;
  logic          line_s;
  logic [CW-1:0] cyc;
  logic [BW-1:0] bitn;
  logic [PW-1:0] shreg;
  logic          mid;
  logic          is_stop;

  assign line_s  = sync[1];
  assign mid     = (state == RX_BITS) && (cyc == CW'(HALF));
  assign is_stop = (bitn == BW'(NBITS - 1));

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], line};
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      state <= RX_IDLE;
      valid <= 1'b0;
      cyc   <= '0;
      bitn  <= '0;
    end else begin
      valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          // line idles high, first low is the start edge
          if (!line_s) begin
            state <= RX_BITS;
            cyc   <= '0;
            bitn  <= '0;
          end
        end
        RX_BITS: begin
          if (cyc == CW'(BIT_CYCLES - 1)) begin
            cyc  <= '0;
            bitn <= bitn + 1'b1;
          end else begin
            cyc <= cyc + 1'b1;
          end
          if (mid) begin
            if (bitn == '0 && line_s) begin
              // start bit gone by mid-bit, a glitch
              state <= RX_IDLE;
            end else if (is_stop) begin
              valid <= line_s;
              state <= line_s ? RX_IDLE : RX_DROP;
            end
          end
        end
        RX_DROP: begin
          if (line_s) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first, so shift in from the top
  always_ff @(posedge clk_sys) begin
    if (mid && bitn != '0 && !is_stop) begin
      shreg <= {line_s, shreg[PW-1:1]};
    end
    if (mid && is_stop) begin
      payload <= payload_t'(shreg);
    end
  end

endmodule

//--- rtl/link_tx.sv
module link_tx #(
  parameter int  BIT_CYCLES = 4,
  parameter type payload_t  = logic [7:0]
) (
  input  logic     clk_sys,
  input  logic     arst_n,
  input  logic     send,
  input  payload_t payload,
  output logic     busy,
  output logic     line
);

  localparam int PW    = $bits(payload_t);
  localparam int NBITS = PW + 2;
  localparam int CW    = $clog2(BIT_CYCLES + 1);
  localparam int BW    = $clog2(NBITS + 1);

  // payload bits then the stop bit, shifted out from bit 0
  logic [PW:0]   shreg;
  logic [CW-1:0] cyc;
  logic [BW-1:0] bitn;
  logic          load;
  logic          bit_end;

  assign load    = send && !busy;
  assign bit_end = busy && (cyc == CW'(BIT_CYCLES - 1));

  always_ff @(posedge clk_sys or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      line <= 1'b1;
      cyc  <= '0;
      bitn <= '0;
    end else if (load) begin
      // start bit goes out right away
      busy <= 1'b1;
      line <= 1'b0;
      cyc  <= '0;
      bitn <= '0;
    end else if (bit_end) begin
      cyc <= '0;
      if (bitn == BW'(NBITS - 1)) begin
        busy <= 1'b0;
        line <= 1'b1;
      end else begin
        line <= shreg[0];
        bitn <= bitn + 1'b1;
      end
    end else if (busy) begin
      cyc <= cyc + 1'b1;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (load) begin
      shreg <= {1'b1, payload};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[PW:1]};
    end
  end

endmodule

//--- rtl/ctrl_link_pkg.sv
package ctrl_link_pkg;

  // broadcast id, every slave writes and none replies
  parameter logic [7:0] BCAST_ID = 8'hFF;

  // only the low address bits reach the slave register file
  parameter int REG_AW = 4;

  typedef struct packed {
    logic       wr;
    logic [7:0] dev_id;
    logic [7:0] addr;
    logic [7:0] data;
  } cmd_frame_t;

  // data is the register value after the command
  typedef struct packed {
    logic [7:0] dev_id;
    logic [7:0] addr;
    logic [7:0] data;
  } reply_frame_t;

  // line bits per frame, start and stop included
  parameter int CMD_FRAME_BITS   = $bits(cmd_frame_t) + 2;
  parameter int REPLY_FRAME_BITS = $bits(reply_frame_t) + 2;

  typedef enum logic [1:0] {
    ST_OK      = 2'd0,
    ST_TIMEOUT = 2'd1,
    ST_BCAST   = 2'd2
  } rsp_status_t;

endpackage
